//--- common/core_pkg.sv
`default_nettype none

package core_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;

    localparam logic [XLEN-1:0] RESET_PC = 32'h8000_0000;
    localparam logic [XLEN-1:0] PC_STEP  = 32'd4;

    // Data memory is word addressed
    localparam int DMEM_WORDS = 64;
    localparam int DMEM_AW    = 6;

    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;

    // Write-back source select
    typedef enum logic [1:0] {
        WB_NONE = 2'b00,
        WB_LINK = 2'b01,
        WB_ALU  = 2'b10,
        WB_LOAD = 2'b11
    } wb_sel_e;

    typedef enum logic [2:0] {
        ALU_ADD    = 3'd0,
        ALU_SUB    = 3'd1,
        ALU_XOR    = 3'd2,
        ALU_OR     = 3'd3,
        ALU_AND    = 3'd4,
        ALU_PASS_B = 3'd5
    } alu_op_e;

    typedef struct packed {
        logic [6:0]            funct7;
        logic [REG_ADDR_W-1:0] rs2;
        logic [REG_ADDR_W-1:0] rs1;
        logic [2:0]            funct3;
        logic [REG_ADDR_W-1:0] rd;
        logic [6:0]            opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0]           imm12;
        logic [REG_ADDR_W-1:0] rs1;
        logic [2:0]            funct3;
        logic [REG_ADDR_W-1:0] rd;
        logic [6:0]            opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0]            imm_hi;
        logic [REG_ADDR_W-1:0] rs2;
        logic [REG_ADDR_W-1:0] rs1;
        logic [2:0]            funct3;
        logic [4:0]            imm_lo;
        logic [6:0]            opcode;
    } s_fmt_t;

    typedef struct packed {
        logic [19:0]           imm20;
        logic [REG_ADDR_W-1:0] rd;
        logic [6:0]            opcode;
    } u_fmt_t;

    // One instruction word, four views
    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        s_fmt_t s;
        u_fmt_t u;
    } inst_u;

endpackage

`default_nettype wire

//--- logic/reg_file.sv
`timescale 1ns/1ps
`default_nettype none

module reg_file (
    input  logic                              clk,
    input  logic                              reset_i,
    input  logic                              we_i,
    input  logic [core_pkg::REG_ADDR_W-1:0]   waddr_i,
    input  logic [core_pkg::XLEN-1:0]         wdata_i,
    input  logic [core_pkg::REG_ADDR_W-1:0]   raddr_a_i,
    input  logic [core_pkg::REG_ADDR_W-1:0]   raddr_b_i,
    output logic [core_pkg::XLEN-1:0]         rdata_a_o,
    output logic [core_pkg::XLEN-1:0]         rdata_b_o
);
    import core_pkg::*;

    // x0 has no storage
    logic [XLEN-1:0] regs [1:(1 << REG_ADDR_W)-1];

    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int i = 1; i < (1 << REG_ADDR_W); i++)
                regs[i] <= '0;
        end else if (we_i && waddr_i != '0) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    assign rdata_a_o = (raddr_a_i == '0) ? '0 : regs[raddr_a_i];
    assign rdata_b_o = (raddr_b_i == '0) ? '0 : regs[raddr_b_i];

endmodule

`default_nettype wire

//--- logic/decode_unit.sv
`timescale 1ns/1ps
`default_nettype none

module decode_unit (
    input  logic                              clk,
    input  logic                              reset_i,
    input  logic                              inst_valid_i,
    input  core_pkg::inst_u                   inst_i,
    input  logic                              wb_done_i,
    input  logic [core_pkg::XLEN-1:0]         rs1_data_i,
    input  logic [core_pkg::XLEN-1:0]         rs2_data_i,
    output logic                              inst_ready_o,
    output logic [core_pkg::REG_ADDR_W-1:0]   rs1_addr_o,
    output logic [core_pkg::REG_ADDR_W-1:0]   rs2_addr_o,
    output logic                              d_valid_o,
    output logic [core_pkg::XLEN-1:0]         d_pc_o,
    output logic [core_pkg::REG_ADDR_W-1:0]   d_rd_o,
    output core_pkg::alu_op_e                 d_alu_op_o,
    output core_pkg::wb_sel_e                 d_wb_sel_o,
    output logic                              d_is_load_o,
    output logic                              d_is_store_o,
    output logic [core_pkg::XLEN-1:0]         d_op_a_o,
    output logic [core_pkg::XLEN-1:0]         d_op_b_o,
    output logic [core_pkg::XLEN-1:0]         d_store_data_o
);
    import core_pkg::*;

    logic            busy_q;
    logic            inst_vld_q;
    inst_u           inst_q;
    logic [XLEN-1:0] pc_q;
    logic            accept;
    logic [XLEN-1:0] imm_i;
    logic [XLEN-1:0] imm_s;
    logic [XLEN-1:0] imm_u;
    alu_op_e         alu_op;
    wb_sel_e         wb_sel;
    logic            is_load;
    logic            is_store;
    logic [XLEN-1:0] op_a;
    logic [XLEN-1:0] op_b;

    // Ready again in the cycle the previous instruction retires
    assign inst_ready_o = !busy_q || wb_done_i;
    assign accept       = inst_valid_i && inst_ready_o;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            busy_q     <= 1'b0;
            inst_vld_q <= 1'b0;
        end else begin
            inst_vld_q <= accept;
            if (accept)
                busy_q <= 1'b1;
            else if (wb_done_i)
                busy_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept)
            inst_q <= inst_i;
    end

    // pc_q is the pc of the instruction held in inst_q
    always_ff @(posedge clk) begin
        if (reset_i)
            pc_q <= RESET_PC;
        else if (inst_vld_q)
            pc_q <= pc_q + PC_STEP;
    end

    assign rs1_addr_o = inst_q.r.rs1;
    assign rs2_addr_o = inst_q.r.rs2;

    assign imm_i = {{(XLEN-12){inst_q.i.imm12[11]}}, inst_q.i.imm12};
    assign imm_s = {{(XLEN-12){inst_q.s.imm_hi[6]}}, inst_q.s.imm_hi, inst_q.s.imm_lo};
    assign imm_u = {inst_q.u.imm20, 12'b0};

    always_comb begin
        alu_op   = ALU_ADD;
        wb_sel   = WB_NONE;
        is_load  = 1'b0;
        is_store = 1'b0;
        op_a     = rs1_data_i;
        op_b     = rs2_data_i;
        case (inst_q.r.opcode)
            OPC_LUI: begin
                alu_op = ALU_PASS_B;
                wb_sel = WB_ALU;
                op_b   = imm_u;
            end
            OPC_AUIPC: begin
                wb_sel = WB_ALU;
                op_a   = pc_q;
                op_b   = imm_u;
            end
            OPC_OP, OPC_OP_IMM: begin
                wb_sel = WB_ALU;
                if (inst_q.r.opcode == OPC_OP_IMM)
                    op_b = imm_i;
                case (inst_q.r.funct3)
                    3'b100:  alu_op = ALU_XOR;
                    3'b110:  alu_op = ALU_OR;
                    3'b111:  alu_op = ALU_AND;
                    // funct7 bit 5 only means SUB in the register form
                    default: alu_op = (inst_q.r.opcode == OPC_OP && inst_q.r.funct7[5]) ?
                                      ALU_SUB : ALU_ADD;
                endcase
            end
            OPC_LOAD: begin
                wb_sel  = WB_LOAD;
                is_load = 1'b1;
                op_b    = imm_i;
            end
            OPC_STORE: begin
                is_store = 1'b1;
                op_b     = imm_s;
            end
            OPC_JAL:  wb_sel = WB_LINK;
            // Target is computed but the trace does not follow it
            OPC_JALR: begin
                wb_sel = WB_LINK;
                op_b   = imm_i;
            end
            default:  wb_sel = WB_NONE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset_i)
            d_valid_o <= 1'b0;
        else
            d_valid_o <= inst_vld_q;
    end

    always_ff @(posedge clk) begin
        if (inst_vld_q) begin
            d_pc_o         <= pc_q;
            d_rd_o         <= inst_q.r.rd;
            d_alu_op_o     <= alu_op;
            d_wb_sel_o     <= wb_sel;
            d_is_load_o    <= is_load;
            d_is_store_o   <= is_store;
            d_op_a_o       <= op_a;
            d_op_b_o       <= op_b;
            d_store_data_o <= rs2_data_i;
        end
    end

    // One instruction in flight, so issue gaps are at least four cycles
    a_issue_gap: assert property (@(posedge clk) disable iff (reset_i)
        accept |=> !accept ##1 !accept ##1 !accept);

endmodule

`default_nettype wire

//--- logic/exec_unit.sv
`timescale 1ns/1ps
`default_nettype none

module exec_unit (
    input  logic                              clk,
    input  logic                              reset_i,
    input  logic                              d_valid_i,
    input  logic [core_pkg::XLEN-1:0]         d_pc_i,
    input  logic [core_pkg::REG_ADDR_W-1:0]   d_rd_i,
    input  core_pkg::alu_op_e                 d_alu_op_i,
    input  core_pkg::wb_sel_e                 d_wb_sel_i,
    input  logic                              d_is_load_i,
    input  logic                              d_is_store_i,
    input  logic [core_pkg::XLEN-1:0]         d_op_a_i,
    input  logic [core_pkg::XLEN-1:0]         d_op_b_i,
    input  logic [core_pkg::XLEN-1:0]         d_store_data_i,
    output logic                              e_valid_o,
    output logic [core_pkg::XLEN-1:0]         e_pc_o,
    output logic [core_pkg::REG_ADDR_W-1:0]   e_rd_o,
    output core_pkg::wb_sel_e                 e_wb_sel_o,
    output logic                              e_is_load_o,
    output logic                              e_is_store_o,
    output logic [core_pkg::XLEN-1:0]         e_result_o,
    output logic [core_pkg::XLEN-1:0]         e_store_data_o
);
    import core_pkg::*;

    logic [XLEN-1:0] alu_res;

    // Also serves as the address adder for loads and stores
    always_comb begin
        case (d_alu_op_i)
            ALU_ADD:    alu_res = d_op_a_i + d_op_b_i;
            ALU_SUB:    alu_res = d_op_a_i - d_op_b_i;
            ALU_XOR:    alu_res = d_op_a_i ^ d_op_b_i;
            ALU_OR:     alu_res = d_op_a_i | d_op_b_i;
            ALU_AND:    alu_res = d_op_a_i & d_op_b_i;
            ALU_PASS_B: alu_res = d_op_b_i;
            default:    alu_res = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset_i)
            e_valid_o <= 1'b0;
        else
            e_valid_o <= d_valid_i;
    end

    always_ff @(posedge clk) begin
        if (d_valid_i) begin
            e_pc_o         <= d_pc_i;
            e_rd_o         <= d_rd_i;
            e_wb_sel_o     <= d_wb_sel_i;
            e_is_load_o    <= d_is_load_i;
            e_is_store_o   <= d_is_store_i;
            e_result_o     <= alu_res;
            e_store_data_o <= d_store_data_i;
        end
    end

    // Decode never marks one instruction as both load and store
    a_ld_st_excl: assert property (@(posedge clk) disable iff (reset_i)
        e_valid_o |-> !(e_is_load_o && e_is_store_o));

endmodule

`default_nettype wire

//--- logic/mem_unit.sv
`timescale 1ns/1ps
`default_nettype none

module mem_unit (
    input  logic                              clk,
    input  logic                              reset_i,
    input  logic                              e_valid_i,
    input  logic [core_pkg::XLEN-1:0]         e_pc_i,
    input  logic [core_pkg::REG_ADDR_W-1:0]   e_rd_i,
    input  core_pkg::wb_sel_e                 e_wb_sel_i,
    input  logic                              e_is_load_i,
    input  logic                              e_is_store_i,
    input  logic [core_pkg::XLEN-1:0]         e_result_i,
    input  logic [core_pkg::XLEN-1:0]         e_store_data_i,
    output logic                              m_valid_o,
    output logic [core_pkg::XLEN-1:0]         m_pc_o,
    output logic [core_pkg::REG_ADDR_W-1:0]   m_rd_o,
    output core_pkg::wb_sel_e                 m_wb_sel_o,
    output logic [core_pkg::XLEN-1:0]         m_result_o,
    output logic [core_pkg::XLEN-1:0]         m_load_data_o
);
    import core_pkg::*;

    logic [XLEN-1:0]    mem [DMEM_WORDS];
    logic [DMEM_AW-1:0] idx;

    // Byte address to word index
    assign idx = e_result_i[DMEM_AW+1:2];

    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int i = 0; i < DMEM_WORDS; i++)
                mem[i] <= '0;
            m_valid_o <= 1'b0;
        end else begin
            if (e_valid_i && e_is_store_i)
                mem[idx] <= e_store_data_i;
            m_valid_o <= e_valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (e_valid_i) begin
            m_pc_o     <= e_pc_i;
            m_rd_o     <= e_rd_i;
            m_wb_sel_o <= e_wb_sel_i;
            m_result_o <= e_result_i;
        end
        if (e_valid_i && e_is_load_i)
            m_load_data_o <= mem[idx];
    end

endmodule

`default_nettype wire

//--- logic/wb_unit.sv
`timescale 1ns/1ps
`default_nettype none

module wb_unit (
    input  logic                              clk,
    input  logic                              reset_i,
    input  logic                              m_valid_i,
    input  logic [core_pkg::XLEN-1:0]         m_pc_i,
    input  logic [core_pkg::REG_ADDR_W-1:0]   m_rd_i,
    input  core_pkg::wb_sel_e                 m_wb_sel_i,
    input  logic [core_pkg::XLEN-1:0]         m_result_i,
    input  logic [core_pkg::XLEN-1:0]         m_load_data_i,
    output logic                              rf_we_o,
    output logic [core_pkg::REG_ADDR_W-1:0]   rf_waddr_o,
    output logic [core_pkg::XLEN-1:0]         rf_wdata_o,
    output logic                              wb_done_o,
    output logic                              wb_valid_o,
    output logic [core_pkg::REG_ADDR_W-1:0]   wb_rd_o,
    output logic [core_pkg::XLEN-1:0]         wb_data_o
);
    import core_pkg::*;

    logic [XLEN-1:0] wb_data;

    // Source of the value written to rd
    always_comb begin
        case (m_wb_sel_i)
            WB_LINK: wb_data = m_pc_i + PC_STEP;
            WB_ALU:  wb_data = m_result_i;
            WB_LOAD: wb_data = m_load_data_i;
            default: wb_data = '0;
        endcase
    end

    // Stores and branches retire without a register write
    assign wb_done_o  = m_valid_i;
    assign wb_valid_o = m_valid_i && (m_wb_sel_i != WB_NONE);
    assign wb_rd_o    = m_rd_i;
    assign wb_data_o  = wb_data;

    // Writes to x0 are still shown but never reach the register file
    assign rf_we_o    = wb_valid_o && (m_rd_i != '0);
    assign rf_waddr_o = m_rd_i;
    assign rf_wdata_o = wb_data;

    // A write is a single-cycle event per retired instruction
    a_we_single: assert property (@(posedge clk) disable iff (reset_i)
        rf_we_o |-> wb_valid_o ##1 !wb_valid_o);

endmodule

`default_nettype wire

//--- logic/core_top.sv
`timescale 1ns/1ps
`default_nettype none

module core_top (
    input  logic                              clk,
    input  logic                              reset_i,
    input  logic                              inst_valid_i,
    input  logic [core_pkg::XLEN-1:0]         inst_i,
    output logic                              inst_ready_o,
    output logic                              wb_valid_o,
    output logic [core_pkg::REG_ADDR_W-1:0]   wb_rd_o,
    output logic [core_pkg::XLEN-1:0]         wb_data_o
);
    import core_pkg::*;

    // Register file ports
    logic [REG_ADDR_W-1:0] rs1_addr;
    logic [REG_ADDR_W-1:0] rs2_addr;
    logic [XLEN-1:0]       rs1_data;
    logic [XLEN-1:0]       rs2_data;
    logic                  rf_we;
    logic [REG_ADDR_W-1:0] rf_waddr;
    logic [XLEN-1:0]       rf_wdata;
    logic                  wb_done;

    // Decode to execute
    logic                  d_valid;
    logic [XLEN-1:0]       d_pc;
    logic [REG_ADDR_W-1:0] d_rd;
    alu_op_e               d_alu_op;
    wb_sel_e               d_wb_sel;
    logic                  d_is_load;
    logic                  d_is_store;
    logic [XLEN-1:0]       d_op_a;
    logic [XLEN-1:0]       d_op_b;
    logic [XLEN-1:0]       d_store_data;

    // Execute to memory
    logic                  e_valid;
    logic [XLEN-1:0]       e_pc;
    logic [REG_ADDR_W-1:0] e_rd;
    wb_sel_e               e_wb_sel;
    logic                  e_is_load;
    logic                  e_is_store;
    logic [XLEN-1:0]       e_result;
    logic [XLEN-1:0]       e_store_data;

    // Memory to write-back
    logic                  m_valid;
    logic [XLEN-1:0]       m_pc;
    logic [REG_ADDR_W-1:0] m_rd;
    wb_sel_e               m_wb_sel;
    logic [XLEN-1:0]       m_result;
    logic [XLEN-1:0]       m_load_data;

    decode_unit u_decode (
        .clk            (clk),
        .reset_i        (reset_i),
        .inst_valid_i   (inst_valid_i),
        .inst_i         (inst_i),
        .wb_done_i      (wb_done),
        .rs1_data_i     (rs1_data),
        .rs2_data_i     (rs2_data),
        .inst_ready_o   (inst_ready_o),
        .rs1_addr_o     (rs1_addr),
        .rs2_addr_o     (rs2_addr),
        .d_valid_o      (d_valid),
        .d_pc_o         (d_pc),
        .d_rd_o         (d_rd),
        .d_alu_op_o     (d_alu_op),
        .d_wb_sel_o     (d_wb_sel),
        .d_is_load_o    (d_is_load),
        .d_is_store_o   (d_is_store),
        .d_op_a_o       (d_op_a),
        .d_op_b_o       (d_op_b),
        .d_store_data_o (d_store_data)
    );

    reg_file u_reg_file (
        .clk       (clk),
        .reset_i   (reset_i),
        .we_i      (rf_we),
        .waddr_i   (rf_waddr),
        .wdata_i   (rf_wdata),
        .raddr_a_i (rs1_addr),
        .raddr_b_i (rs2_addr),
        .rdata_a_o (rs1_data),
        .rdata_b_o (rs2_data)
    );

    exec_unit u_exec (
        .clk            (clk),
        .reset_i        (reset_i),
        .d_valid_i      (d_valid),
        .d_pc_i         (d_pc),
        .d_rd_i         (d_rd),
        .d_alu_op_i     (d_alu_op),
        .d_wb_sel_i     (d_wb_sel),
        .d_is_load_i    (d_is_load),
        .d_is_store_i   (d_is_store),
        .d_op_a_i       (d_op_a),
        .d_op_b_i       (d_op_b),
        .d_store_data_i (d_store_data),
        .e_valid_o      (e_valid),
        .e_pc_o         (e_pc),
        .e_rd_o         (e_rd),
        .e_wb_sel_o     (e_wb_sel),
        .e_is_load_o    (e_is_load),
        .e_is_store_o   (e_is_store),
        .e_result_o     (e_result),
        .e_store_data_o (e_store_data)
    );

    mem_unit u_mem (
        .clk            (clk),
        .reset_i        (reset_i),
        .e_valid_i      (e_valid),
        .e_pc_i         (e_pc),
        .e_rd_i         (e_rd),
        .e_wb_sel_i     (e_wb_sel),
        .e_is_load_i    (e_is_load),
        .e_is_store_i   (e_is_store),
        .e_result_i     (e_result),
        .e_store_data_i (e_store_data),
        .m_valid_o      (m_valid),
        .m_pc_o         (m_pc),
        .m_rd_o         (m_rd),
        .m_wb_sel_o     (m_wb_sel),
        .m_result_o     (m_result),
        .m_load_data_o  (m_load_data)
    );

    wb_unit u_wb (
        .clk           (clk),
        .reset_i       (reset_i),
        .m_valid_i     (m_valid),
        .m_pc_i        (m_pc),
        .m_rd_i        (m_rd),
        .m_wb_sel_i    (m_wb_sel),
        .m_result_i    (m_result),
        .m_load_data_i (m_load_data),
        .rf_we_o       (rf_we),
        .rf_waddr_o    (rf_waddr),
        .rf_wdata_o    (rf_wdata),
        .wb_done_o     (wb_done),
        .wb_valid_o    (wb_valid_o),
        .wb_rd_o       (wb_rd_o),
        .wb_data_o     (wb_data_o)
    );

endmodule

`default_nettype wire

//--- sim/tb_core.sv
`timescale 1ns/1ps
`default_nettype none

module tb_core;
    import core_pkg::*;

    localparam int NUM_INSTS      = 400;
    localparam int RESET_CYCLES   = 8;
    localparam int MARGIN_CYCLES  = 392;
    localparam int TIMEOUT_CYCLES = NUM_INSTS * 4 + RESET_CYCLES + MARGIN_CYCLES;

    logic                  clk;
    logic                  reset_i;
    logic                  inst_valid_i;
    logic [XLEN-1:0]       inst_i;
    logic                  inst_ready_o;
    logic                  wb_valid_o;
    logic [REG_ADDR_W-1:0] wb_rd_o;
    logic [XLEN-1:0]       wb_data_o;

    // Reference model state
    logic [XLEN-1:0] model_regs [32];
    logic [XLEN-1:0] model_mem [DMEM_WORDS];
    logic [XLEN-1:0] model_pc;

    // Trace and the expected write-back of each entry
    logic [XLEN-1:0]       prog_word [NUM_INSTS];
    logic                  exp_write [NUM_INSTS];
    logic [REG_ADDR_W-1:0] exp_rd [NUM_INSTS];
    logic [XLEN-1:0]       exp_data [NUM_INSTS];
    int                    accept_edge [NUM_INSTS];

    int seed;
    int gen_count       = 0;
    int issue_count     = 0;
    int check_count     = 0;
    int cycle_cnt       = 0;
    int mismatch_count  = 0;
    int stray_count     = 0;
    int handshake_count = 0;

    core_top dut (
        .clk          (clk),
        .reset_i      (reset_i),
        .inst_valid_i (inst_valid_i),
        .inst_i       (inst_i),
        .inst_ready_o (inst_ready_o),
        .wb_valid_o   (wb_valid_o),
        .wb_rd_o      (wb_rd_o),
        .wb_data_o    (wb_data_o)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk)
        cycle_cnt <= cycle_cnt + 1;

    function automatic int rand_below(input int n);
        logic [31:0] r;
        r = $random(seed);
        return int'(r % n);
    endfunction

    function automatic logic [31:0] rand_word();
        logic [31:0] r;
        r = $random(seed);
        return r;
    endfunction

    // Only x0 to x7 appear in the trace
    function automatic logic [4:0] rand_reg();
        return 5'(rand_below(8));
    endfunction

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd, input logic [6:0] opc);
        return {f7, rs2, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [6:0] opc);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], opc};
    endfunction

    function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [4:0] rd,
                                          input logic [6:0] opc);
        return {imm, rd, opc};
    endfunction

    // RV32I integer ops selected by funct3
    function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic sub,
                                            input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'b000:  return sub ? a - b : a + b;
            3'b100:  return a ^ b;
            3'b110:  return a | b;
            3'b111:  return a & b;
            default: return 32'h0;
        endcase
    endfunction

    // Executes one word on the model and records what write-back it must produce
    task automatic model_step(input logic [31:0] w);
        logic [6:0]  opc;
        logic [4:0]  rd;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm_i;
        logic [31:0] imm_s;
        logic [31:0] imm_u;
        logic [31:0] addr;
        logic [31:0] res;
        logic        wr;
        opc   = w[6:0];
        rd    = w[11:7];
        a     = model_regs[w[19:15]];
        b     = model_regs[w[24:20]];
        imm_i = {{20{w[31]}}, w[31:20]};
        imm_s = {{20{w[31]}}, w[31:25], w[11:7]};
        imm_u = {w[31:12], 12'b0};
        wr    = 1'b1;
        res   = 32'h0;
        case (opc)
            OPC_LUI:    res = imm_u;
            OPC_AUIPC:  res = model_pc + imm_u;
            OPC_OP:     res = alu_ref(w[14:12], w[30], a, b);
            OPC_OP_IMM: res = alu_ref(w[14:12], 1'b0, a, imm_i);
            OPC_LOAD: begin
                addr = a + imm_i;
                res  = model_mem[addr[DMEM_AW+1:2]];
            end
            OPC_STORE: begin
                addr = a + imm_s;
                model_mem[addr[DMEM_AW+1:2]] = b;
                wr = 1'b0;
            end
            OPC_JAL, OPC_JALR: res = model_pc + 32'd4;
            default:    wr = 1'b0;
        endcase
        prog_word[gen_count] = w;
        exp_write[gen_count] = wr;
        exp_rd[gen_count]    = rd;
        exp_data[gen_count]  = res;
        if (wr && rd != 5'd0)
            model_regs[rd] = res;
        model_pc  = model_pc + 32'd4;
        gen_count = gen_count + 1;
    endtask

    // One random instruction, or a short group for memory accesses
    task automatic gen_group();
        int          kind;
        int          o;
        int          w;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [4:0]  base;
        logic [2:0]  f3;
        logic [31:0] word;
        logic [11:0] off;
        logic [11:0] base_val;
        kind = rand_below(12);
        if (NUM_INSTS - gen_count < 3 && kind >= 10)
            kind = rand_below(10);
        rd   = rand_reg();
        rs1  = rand_reg();
        rs2  = rand_reg();
        base = 5'(1 + rand_below(7));
        word = rand_word();
        // Word-aligned address that stays inside the data memory
        o        = rand_below(4);
        w        = o + rand_below(DMEM_WORDS - o);
        off      = 12'(o * 4);
        base_val = 12'((w - o) * 4);
        case (kind)
            0, 1: begin
                case (rand_below(5))
                    0:       model_step(enc_r(7'h00, rs2, rs1, 3'b000, rd, OPC_OP));
                    1:       model_step(enc_r(7'h20, rs2, rs1, 3'b000, rd, OPC_OP));
                    2:       model_step(enc_r(7'h00, rs2, rs1, 3'b100, rd, OPC_OP));
                    3:       model_step(enc_r(7'h00, rs2, rs1, 3'b110, rd, OPC_OP));
                    default: model_step(enc_r(7'h00, rs2, rs1, 3'b111, rd, OPC_OP));
                endcase
            end
            2, 3, 9: begin
                case (rand_below(4))
                    0:       f3 = 3'b000;
                    1:       f3 = 3'b100;
                    2:       f3 = 3'b110;
                    default: f3 = 3'b111;
                endcase
                model_step(enc_i(word[11:0], rs1, f3, rd, OPC_OP_IMM));
            end
            4: model_step(enc_u(word[31:12], rd, OPC_LUI));
            5: model_step(enc_u(word[31:12], rd, OPC_AUIPC));
            6: model_step(enc_u(word[31:12], rd, OPC_JAL));
            7: model_step(enc_i(word[11:0], rs1, 3'b000, rd, OPC_JALR));
            8: model_step(enc_s(word[11:0], rs2, rs1, 3'b000, OPC_BRANCH));
            10: begin
                model_step(enc_i(base_val, 5'd0, 3'b000, base, OPC_OP_IMM));
                model_step(enc_i(off, base, 3'b010, rd, OPC_LOAD));
            end
            default: begin
                model_step(enc_i(base_val, 5'd0, 3'b000, base, OPC_OP_IMM));
                model_step(enc_s(off, rs2, base, 3'b010, OPC_STORE));
                if (rand_below(2) == 0)
                    model_step(enc_i(off, base, 3'b010, rd, OPC_LOAD));
            end
        endcase
    endtask

    // Called on a falling edge, returns on the falling edge after acceptance
    task automatic issue(input int n);
        inst_valid_i = 1'b1;
        inst_i       = prog_word[n];
        while (!inst_ready_o)
            @(negedge clk);
        accept_edge[n] = cycle_cnt + 1;
        if (n > 0 && accept_edge[n] < accept_edge[n-1] + 4) begin
            handshake_count = handshake_count + 1;
            $display("Error: instruction %0d accepted at edge %0d, before the write edge %0d",
                     n, accept_edge[n], accept_edge[n-1] + 4);
        end
        issue_count = n + 1;
        @(negedge clk);
    endtask

    task automatic check_writeback(input int n);
        if (exp_write[n]) begin
            if (!wb_valid_o) begin
                mismatch_count = mismatch_count + 1;
                $display("MISMATCH at %0t: instruction %0d gave no write-back to x%0d",
                         $time, n, exp_rd[n]);
            end else begin
                if (wb_rd_o !== exp_rd[n]) begin
                    mismatch_count = mismatch_count + 1;
                    $display("MISMATCH at %0t: instruction %0d rd x%0d, expected x%0d",
                             $time, n, wb_rd_o, exp_rd[n]);
                end
                if (wb_data_o !== exp_data[n]) begin
                    mismatch_count = mismatch_count + 1;
                    $display("MISMATCH at %0t: instruction %0d data %h, expected %h",
                             $time, n, wb_data_o, exp_data[n]);
                end
            end
        end else if (wb_valid_o) begin
            mismatch_count = mismatch_count + 1;
            $display("MISMATCH at %0t: instruction %0d has no rd but raised wb_valid_o",
                     $time, n);
        end
    endtask

    // Write-back is due in the cycle after the third edge past acceptance
    always @(negedge clk) begin
        if (!reset_i) begin
            if (check_count < issue_count && accept_edge[check_count] + 3 == cycle_cnt) begin
                check_writeback(check_count);
                check_count = check_count + 1;
            end else if (wb_valid_o) begin
                stray_count = stray_count + 1;
                $display("Error: write-back to x%0d at time %0t with no instruction due",
                         wb_rd_o, $time);
            end
        end
    end

    initial begin
        while (cycle_cnt < TIMEOUT_CYCLES)
            @(posedge clk);
        $display("Error: timeout after %0d cycles, %0d of %0d instructions checked",
                 TIMEOUT_CYCLES, check_count, NUM_INSTS);
        $display("Simulation failed");
        $finish;
    end

    initial begin
        reset_i      = 1'b1;
        inst_valid_i = 1'b0;
        inst_i       = '0;
        seed         = 32'h71d2;
        model_pc     = RESET_PC;
        for (int i = 0; i < 32; i++)
            model_regs[i] = '0;
        for (int i = 0; i < DMEM_WORDS; i++)
            model_mem[i] = '0;
        while (gen_count < NUM_INSTS)
            gen_group();

        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        reset_i = 1'b0;
        if (!inst_ready_o || wb_valid_o) begin
            handshake_count = handshake_count + 1;
            $display("Error: after reset inst_ready_o is %b and wb_valid_o is %b",
                     inst_ready_o, wb_valid_o);
        end

        for (int n = 0; n < NUM_INSTS; n++)
            issue(n);
        inst_valid_i = 1'b0;

        while (check_count < NUM_INSTS)
            @(negedge clk);
        // A few idle cycles to catch late write-backs
        repeat (4) @(negedge clk);

        $display("Summary: %0d mismatches, %0d stray write-backs, %0d handshake errors",
                 mismatch_count, stray_count, handshake_count);
        if (mismatch_count == 0 && stray_count == 0 && handshake_count == 0)
            $display("Simulation passed");
        else
            $display("Simulation failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- all.f
common/core_pkg.sv
logic/reg_file.sv
logic/decode_unit.sv
logic/exec_unit.sv
logic/mem_unit.sv
logic/wb_unit.sv
logic/core_top.sv
sim/tb_core.sv

//--- run.sh
#!/bin/sh
# Build and run the core testbench with Verilator

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir
verilator --binary --timing --assert --top-module tb_core -f all.f -o tb_core
if [ $? -ne 0 ]; then
    echo "Verilator compile failed"
    exit 1
fi

./obj_dir/tb_core > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^Simulation passed$" sim.log; then
    exit 0
fi
exit 1
